// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing -f rv32e_core.f --top-module tb_rv32e_core
	./obj_dir/Vtb_rv32e_core | tee /dev/stderr | grep -q "Simulation passed"

lint:
	verilator --lint-only -Wall -f rv32e_core.f --top-module rv32e_core

clean:
	rm -rf obj_dir

// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

	// Datapath and register index widths of RV32E
	localparam int xlen       = 32;
	localparam int reg_addr_w = 4;

	// Major opcodes, bits [6:0] of the instruction
	localparam logic [6:0] opcode_op     = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;
	localparam logic [6:0] opcode_lui    = 7'b0110111;
	localparam logic [6:0] opcode_auipc  = 7'b0010111;
	localparam logic [6:0] opcode_jal    = 7'b1101111;
	localparam logic [6:0] opcode_jalr   = 7'b1100111;
	localparam logic [6:0] opcode_branch = 7'b1100011;

	// funct3 of the ALU classes
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// funct3 of the conditional branches
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	typedef enum logic [2:0] {
		opc_op,
		opc_op_imm,
		opc_lui,
		opc_auipc,
		opc_jal,
		opc_jalr,
		opc_branch,
		opc_illegal
	} op_class_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

endpackage

`default_nettype wire

// File: decode/idu.sv
`default_nettype none

module idu import core_pkg::*; (
	input  wire                    clock,
	input  wire                    rst_n,
	input  wire                    inst_valid,
	input  wire [xlen-1:0]         inst,
	input  wire [xlen-1:0]         pc,
	input  wire                    squash,
	input  wire [xlen-1:0]         rf_rdata1,
	input  wire [xlen-1:0]         rf_rdata2,
	input  wire                    ex_valid,
	input  wire [reg_addr_w-1:0]   ex_rd,
	input  wire                    ex_rd_wen,
	input  wire [xlen-1:0]         ex_val,
	output logic [reg_addr_w-1:0]  rs1,
	output logic [reg_addr_w-1:0]  rs2,
	output logic                   id_valid,
	output logic [xlen-1:0]        id_pc,
	output op_class_e              id_op_class,
	output alu_op_e                id_alu_op,
	output logic [2:0]             id_funct3,
	output logic [reg_addr_w-1:0]  id_rd,
	output logic                   id_rd_wen,
	output logic [xlen-1:0]        id_src1,
	output logic [xlen-1:0]        id_src2,
	output logic [xlen-1:0]        id_imm
);

	logic            valid_q;
	logic [xlen-1:0] inst_q;
	logic [xlen-1:0] pc_q;

	logic [6:0]      opcode;
	op_class_e       raw_class;
	logic            uses_rd;
	logic            uses_rs1;
	logic            uses_rs2;
	logic            bad_reg;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic [xlen-1:0] imm_b;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= inst_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid) begin
			inst_q <= inst;
			pc_q   <= pc;
		end
	end

	// Wrong-path slot behind a taken transfer is dropped here
	assign id_valid  = valid_q & ~squash;
	assign id_pc     = pc_q;
	assign opcode    = inst_q[6:0];
	assign id_funct3 = inst_q[14:12];
	assign id_rd     = inst_q[10:7];
	assign rs1       = inst_q[18:15];
	assign rs2       = inst_q[23:20];

	always_comb begin
		case (opcode)
			opcode_op:     raw_class = opc_op;
			opcode_op_imm: raw_class = opc_op_imm;
			opcode_lui:    raw_class = opc_lui;
			opcode_auipc:  raw_class = opc_auipc;
			opcode_jal:    raw_class = opc_jal;
			opcode_jalr:   raw_class = opc_jalr;
			opcode_branch: raw_class = opc_branch;
			default:       raw_class = opc_illegal;
		endcase
	end

	// Register fields only count where the format has them
	assign uses_rd  = (raw_class != opc_branch) && (raw_class != opc_illegal);
	assign uses_rs1 = (raw_class == opc_op) || (raw_class == opc_op_imm) ||
	                  (raw_class == opc_jalr) || (raw_class == opc_branch);
	assign uses_rs2 = (raw_class == opc_op) || (raw_class == opc_branch);
	assign bad_reg  = (uses_rd & inst_q[11]) | (uses_rs1 & inst_q[19]) |
	                  (uses_rs2 & inst_q[24]);

	assign id_op_class = bad_reg ? opc_illegal : raw_class;
	assign id_rd_wen   = uses_rd && !bad_reg && (id_rd != '0);

	always_comb begin
		id_alu_op = alu_add;
		if ((id_op_class == opc_op) || (id_op_class == opc_op_imm)) begin
			case (id_funct3)
				f3_add:  id_alu_op = ((id_op_class == opc_op) && inst_q[30]) ? alu_sub : alu_add;
				f3_sll:  id_alu_op = alu_sll;
				f3_slt:  id_alu_op = alu_slt;
				f3_sltu: id_alu_op = alu_sltu;
				f3_xor:  id_alu_op = alu_xor;
				f3_sr:   id_alu_op = inst_q[30] ? alu_sra : alu_srl;
				f3_or:   id_alu_op = alu_or;
				f3_and:  id_alu_op = alu_and;
				default: id_alu_op = alu_add;
			endcase
		end
	end

	assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
	assign imm_u = {inst_q[31:12], 12'b0};
	assign imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
	assign imm_b = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};

	always_comb begin
		case (id_op_class)
			opc_op_imm, opc_jalr: id_imm = imm_i;
			opc_lui, opc_auipc:   id_imm = imm_u;
			opc_jal:              id_imm = imm_j;
			opc_branch:           id_imm = imm_b;
			default:              id_imm = '0;
		endcase
	end

	// Bypass from the execute result register, older results are already in the RF
	assign id_src1 = (ex_valid && ex_rd_wen && (ex_rd == rs1)) ? ex_val : rf_rdata1;
	assign id_src2 = (ex_valid && ex_rd_wen && (ex_rd == rs2)) ? ex_val : rf_rdata2;

endmodule

`default_nettype wire

// File: dv/rv32e_model.sv
`default_nettype none

module rv32e_model import core_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		int unsigned edge_n;
		logic [31:0] pc;
		logic [3:0]  rd;
		logic        wen;
		logic [31:0] data;
		logic        illegal;
	} retire_t;

	// Expected retire records and redirects, in program order
	retire_t     wb_q[$];
	logic [31:0] redir_q[$];
	int unsigned redir_edge_q[$];

	logic [31:0] regs [16];
	logic        last_taken;

	initial begin
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		last_taken = 1'b0;
	end

	function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
	                                    input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	// An edge with no acceptance breaks the squash shadow
	task automatic idle();
		last_taken = 1'b0;
	endtask

	task automatic accept(input logic [31:0] ins, input logic [31:0] ipc,
	                      input int unsigned edge_n);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] res;
		logic [31:0] tgt;
		logic        ill;
		logic        wr;
		logic        tk;
		retire_t     r;
		rd    = ins[11:7];
		rs1   = ins[19:15];
		rs2   = ins[24:20];
		f3    = ins[14:12];
		a     = regs[rs1[3:0]];
		b     = regs[rs2[3:0]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		res   = '0;
		tgt   = '0;
		ill   = 1'b0;
		wr    = 1'b1;
		tk    = 1'b0;
		if (last_taken) begin
			// Wrong-path slot, never retires
			last_taken = 1'b0;
			return;
		end
		case (ins[6:0])
			opcode_op: begin
				ill = rd[4] | rs1[4] | rs2[4];
				res = alu(f3, ins[30], a, b);
			end
			opcode_op_imm: begin
				ill = rd[4] | rs1[4];
				res = alu(f3, ins[30] && (f3 == 3'd5), a, imm_i);
			end
			opcode_lui: begin
				ill = rd[4];
				res = {ins[31:12], 12'b0};
			end
			opcode_auipc: begin
				ill = rd[4];
				res = ipc + {ins[31:12], 12'b0};
			end
			opcode_jal: begin
				ill = rd[4];
				res = ipc + 32'd4;
				tk  = 1'b1;
				tgt = ipc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			opcode_jalr: begin
				ill = rd[4] | rs1[4];
				res = ipc + 32'd4;
				tk  = 1'b1;
				tgt = (a + imm_i) & ~32'd1;
			end
			opcode_branch: begin
				ill = rs1[4] | rs2[4];
				wr  = 1'b0;
				tgt = ipc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				case (f3)
					3'd0: tk = (a == b);
					3'd1: tk = (a != b);
					3'd4: tk = $signed(a) < $signed(b);
					3'd5: tk = $signed(a) >= $signed(b);
					3'd6: tk = a < b;
					3'd7: tk = a >= b;
					default: tk = 1'b0;
				endcase
			end
			default: ill = 1'b1;
		endcase
		if (ill) begin
			wr = 1'b0;
			tk = 1'b0;
		end
		wr = wr && (rd[3:0] != 4'd0);
		if (wr) begin
			regs[rd[3:0]] = res;
		end
		r = '{edge_n: edge_n, pc: ipc, rd: ins[10:7], wen: wr, data: res, illegal: ill};
		wb_q.push_back(r);
		if (tk) begin
			redir_q.push_back(tgt);
			redir_edge_q.push_back(edge_n);
		end
		last_taken = tk;
	endtask

endmodule

`default_nettype wire

// File: dv/tb_rv32e_core.sv
`default_nettype none

module tb_rv32e_core import core_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int per_phase     = 60;
	localparam int stim_count    = 6 * per_phase;
	localparam int timeout_limit = 2 * stim_count + 50;

	logic        clock;
	logic        rst_n;
	logic        inst_valid;
	logic [31:0] inst;
	logic [31:0] pc;
	logic        wb_valid;
	logic [31:0] wb_pc;
	logic [3:0]  wb_rd;
	logic        wb_wen;
	logic [31:0] wb_data;
	logic        wb_illegal;
	logic        redirect_valid;
	logic [31:0] redirect_pc;

	logic [31:0] lfsr = 32'h0a82e9fe;
	int unsigned edge_cnt = 0;
	int unsigned cycles = 0;
	logic [3:0]  prev_rd = '0;

	rv32e_core DUT (.*);
	rv32e_model model ();

	always #4 clock = ~clock;

	function automatic logic [31:0] rnd(input int nbits);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Index above 15 only in the illegal phase
	function automatic logic [4:0] pick_reg(input int phase);
		logic bad;
		bad = (phase == 5) && (rnd(3) == 0);
		return {bad, 4'(rnd(4))};
	endfunction

	function automatic logic [31:0] alu_inst(input int phase, input logic [4:0] rs1,
	                                         input logic [4:0] rd);
		logic [2:0] f3;
		logic       alt;
		f3  = 3'(rnd(3));
		alt = 1'(rnd(1));
		if (rnd(1)) begin
			return {1'b0, alt && (f3 == 0 || f3 == 5), 5'b0, pick_reg(phase), rs1, f3, rd,
			        opcode_op};
		end else if (f3 == 1 || f3 == 5) begin
			return {1'b0, alt && f3 == 5, 5'b0, 5'(rnd(5)), rs1, f3, rd, opcode_op_imm};
		end
		return {12'(rnd(12)), rs1, f3, rd, opcode_op_imm};
	endfunction

	function automatic logic [31:0] gen_inst(input int phase, input int idx);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [31:0] w;
		rd  = pick_reg(phase);
		rs1 = pick_reg(phase);
		rs2 = rnd(1) ? rs1 : pick_reg(phase);
		f3  = 3'(rnd(3));
		case (phase)
			0: w = alu_inst(phase, rs1, rd);
			1: w = alu_inst(phase, {1'b0, prev_rd}, rd);
			2: begin
				case (rnd(2))
					0: w = {20'(rnd(20)), rd, opcode_lui};
					1: w = {20'(rnd(20)), rd, opcode_auipc};
					2: w = {20'(rnd(20)), rd, opcode_jal};
					default: w = {12'(rnd(12)), rs1, 3'b000, rd, opcode_jalr};
				endcase
			end
			3: begin
				if (f3 == 2 || f3 == 3) begin
					f3 = f3 + 3'd4;
				end
				w = {7'(rnd(7)), rs2, rs1, f3, 5'(rnd(5)), opcode_branch};
			end
			4: begin
				// Taken JAL, then a shadowed write, then an ADD reading it back
				case (idx % 3)
					0: w = {20'(rnd(20)), rd, opcode_jal};
					1: w = {12'(rnd(12)), rs1, 3'b000, rd, opcode_op_imm};
					default: w = {7'b0, 5'b0, 1'b0, prev_rd, 3'b000, rd, opcode_op};
				endcase
			end
			default: w = (rnd(2) == 0) ? {25'(rnd(25)), 7'b0000011} : alu_inst(phase, rs1, rd);
		endcase
		if (!(phase == 4 && idx % 3 == 2)) begin
			prev_rd = w[10:7];
		end
		return w;
	endfunction

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	initial begin
		clock      = 1'b0;
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		pc         = '0;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
		for (int ph = 0; ph < 6; ph++) begin
			for (int i = 0; i < per_phase; i++) begin
				@(posedge clock);
				edge_cnt++;
				if (rst_n && inst_valid) begin
					model.accept(inst, pc, edge_cnt);
				end else begin
					model.idle();
				end
				inst_valid <= (ph == 1 || ph == 4) ? 1'b1 : (rnd(2) != 0);
				inst       <= gen_inst(ph, i);
				pc         <= {30'(rnd(30)), 2'b00};
			end
		end
		@(posedge clock);
		edge_cnt++;
		if (inst_valid) begin
			model.accept(inst, pc, edge_cnt);
		end
		inst_valid <= 1'b0;
		repeat (6) begin
			@(posedge clock);
			edge_cnt++;
		end
		if (model.wb_q.size() != 0 || model.redir_q.size() != 0) begin
			$display("Expected retires or redirects never appeared");
			$display("Simulation failed");
			$fatal(1, "records left over");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clock) begin
		if (rst_n) begin
			check("wb_valid", 32'(model.wb_q.size() > 0 && model.wb_q[0].edge_n + 2 == edge_cnt),
			      32'(wb_valid));
			if (wb_valid) begin
				check("wb_pc", model.wb_q[0].pc, wb_pc);
				check("wb_rd", 32'(model.wb_q[0].rd), 32'(wb_rd));
				check("wb_wen", 32'(model.wb_q[0].wen), 32'(wb_wen));
				check("wb_illegal", 32'(model.wb_q[0].illegal), 32'(wb_illegal));
				if (model.wb_q[0].wen) begin
					check("wb_data", model.wb_q[0].data, wb_data);
				end
				void'(model.wb_q.pop_front());
			end
			check("redirect_valid",
			      32'(model.redir_q.size() > 0 && model.redir_edge_q[0] + 1 == edge_cnt),
			      32'(redirect_valid));
			if (redirect_valid) begin
				check("redirect_pc", model.redir_q[0], redirect_pc);
				void'(model.redir_q.pop_front());
				void'(model.redir_edge_q.pop_front());
			end
		end
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit) begin
			$display("Timeout, the run did not finish in %0d cycles", timeout_limit);
			stop_run();
		end
	end

endmodule

`default_nettype wire

// File: execute/exu.sv
`default_nettype none

module exu import core_pkg::*; (
	input  wire                    clock,
	input  wire                    rst_n,
	input  wire                    id_valid,
	input  wire [xlen-1:0]         id_pc,
	input  op_class_e              id_op_class,
	input  alu_op_e                id_alu_op,
	input  wire [2:0]              id_funct3,
	input  wire [reg_addr_w-1:0]   id_rd,
	input  wire                    id_rd_wen,
	input  wire [xlen-1:0]         id_src1,
	input  wire [xlen-1:0]         id_src2,
	input  wire [xlen-1:0]         id_imm,
	output logic                   ex_valid,
	output logic [xlen-1:0]        ex_pc,
	output logic [reg_addr_w-1:0]  ex_rd,
	output logic                   ex_rd_wen,
	output logic [xlen-1:0]        ex_val,
	output logic                   ex_illegal,
	output logic                   redirect_valid,
	output logic [xlen-1:0]        redirect_pc
);

	logic [xlen-1:0] op_b;
	logic [4:0]      shamt;
	logic [xlen-1:0] alu_res;
	logic [xlen-1:0] rd_val;
	logic            br_cond;
	logic            taken;
	logic [xlen-1:0] target;

	// Register-register uses rs2, everything else the immediate
	assign op_b  = (id_op_class == opc_op) ? id_src2 : id_imm;
	assign shamt = op_b[4:0];

	always_comb begin
		case (id_alu_op)
			alu_add:  alu_res = id_src1 + op_b;
			alu_sub:  alu_res = id_src1 - op_b;
			alu_sll:  alu_res = id_src1 << shamt;
			alu_slt:  alu_res = {31'b0, $signed(id_src1) < $signed(op_b)};
			alu_sltu: alu_res = {31'b0, id_src1 < op_b};
			alu_xor:  alu_res = id_src1 ^ op_b;
			alu_srl:  alu_res = id_src1 >> shamt;
			alu_sra:  alu_res = $signed(id_src1) >>> shamt;
			alu_or:   alu_res = id_src1 | op_b;
			alu_and:  alu_res = id_src1 & op_b;
			default:  alu_res = '0;
		endcase
	end

	always_comb begin
		case (id_op_class)
			opc_lui:           rd_val = id_imm;
			opc_auipc:         rd_val = id_pc + id_imm;
			opc_jal, opc_jalr: rd_val = id_pc + 32'd4;
			default:           rd_val = alu_res;
		endcase
	end

	// funct3 010 and 011 are not branches and never take
	always_comb begin
		case (id_funct3)
			f3_beq:  br_cond = (id_src1 == id_src2);
			f3_bne:  br_cond = (id_src1 != id_src2);
			f3_blt:  br_cond = ($signed(id_src1) < $signed(id_src2));
			f3_bge:  br_cond = ($signed(id_src1) >= $signed(id_src2));
			f3_bltu: br_cond = (id_src1 < id_src2);
			f3_bgeu: br_cond = (id_src1 >= id_src2);
			default: br_cond = 1'b0;
		endcase
	end

	assign taken = (id_op_class == opc_jal) || (id_op_class == opc_jalr) ||
	               ((id_op_class == opc_branch) && br_cond);

	assign target = (id_op_class == opc_jalr) ? ((id_src1 + id_imm) & ~32'd1)
	                                          : (id_pc + id_imm);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ex_valid       <= 1'b0;
			ex_rd_wen      <= 1'b0;
			ex_illegal     <= 1'b0;
			redirect_valid <= 1'b0;
		end else begin
			ex_valid       <= id_valid;
			ex_rd_wen      <= id_valid & id_rd_wen;
			ex_illegal     <= id_valid && (id_op_class == opc_illegal);
			redirect_valid <= id_valid & taken;
		end
	end

	always_ff @(posedge clock) begin
		ex_pc       <= id_pc;
		ex_rd       <= id_rd;
		ex_val      <= rd_val;
		redirect_pc <= target;
	end

endmodule

`default_nettype wire

// File: rv32e_core.f
common/core_pkg.sv
decode/idu.sv
execute/exu.sv
src/wbu.sv
src/rv32e_core.sv
dv/rv32e_model.sv
dv/tb_rv32e_core.sv

// File: src/rv32e_core.sv
`default_nettype none

module rv32e_core import core_pkg::*; (
	input  wire                    clock,
	input  wire                    rst_n,
	input  wire                    inst_valid,
	input  wire [xlen-1:0]         inst,
	input  wire [xlen-1:0]         pc,
	output logic                   wb_valid,
	output logic [xlen-1:0]        wb_pc,
	output logic [reg_addr_w-1:0]  wb_rd,
	output logic                   wb_wen,
	output logic [xlen-1:0]        wb_data,
	output logic                   wb_illegal,
	output logic                   redirect_valid,
	output logic [xlen-1:0]        redirect_pc
);

	// Decode to execute
	logic                  id_valid;
	logic [xlen-1:0]       id_pc;
	op_class_e             id_op_class;
	alu_op_e               id_alu_op;
	logic [2:0]            id_funct3;
	logic [reg_addr_w-1:0] id_rd;
	logic                  id_rd_wen;
	logic [xlen-1:0]       id_src1;
	logic [xlen-1:0]       id_src2;
	logic [xlen-1:0]       id_imm;

	// Execute to writeback, also the bypass path
	logic                  ex_valid;
	logic [xlen-1:0]       ex_pc;
	logic [reg_addr_w-1:0] ex_rd;
	logic                  ex_rd_wen;
	logic [xlen-1:0]       ex_val;
	logic                  ex_illegal;

	// Register file read ports
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [xlen-1:0]       rf_rdata1;
	logic [xlen-1:0]       rf_rdata2;

	idu u_idu (
		.clock(clock),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.inst(inst),
		.pc(pc),
		.squash(redirect_valid),
		.rf_rdata1(rf_rdata1),
		.rf_rdata2(rf_rdata2),
		.ex_valid(ex_valid),
		.ex_rd(ex_rd),
		.ex_rd_wen(ex_rd_wen),
		.ex_val(ex_val),
		.rs1(rs1),
		.rs2(rs2),
		.id_valid(id_valid),
		.id_pc(id_pc),
		.id_op_class(id_op_class),
		.id_alu_op(id_alu_op),
		.id_funct3(id_funct3),
		.id_rd(id_rd),
		.id_rd_wen(id_rd_wen),
		.id_src1(id_src1),
		.id_src2(id_src2),
		.id_imm(id_imm)
	);

	exu u_exu (
		.clock(clock),
		.rst_n(rst_n),
		.id_valid(id_valid),
		.id_pc(id_pc),
		.id_op_class(id_op_class),
		.id_alu_op(id_alu_op),
		.id_funct3(id_funct3),
		.id_rd(id_rd),
		.id_rd_wen(id_rd_wen),
		.id_src1(id_src1),
		.id_src2(id_src2),
		.id_imm(id_imm),
		.ex_valid(ex_valid),
		.ex_pc(ex_pc),
		.ex_rd(ex_rd),
		.ex_rd_wen(ex_rd_wen),
		.ex_val(ex_val),
		.ex_illegal(ex_illegal),
		.redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc)
	);

	wbu u_wbu (
		.clock(clock),
		.rst_n(rst_n),
		.ex_valid(ex_valid),
		.ex_pc(ex_pc),
		.ex_rd(ex_rd),
		.ex_rd_wen(ex_rd_wen),
		.ex_val(ex_val),
		.ex_illegal(ex_illegal),
		.rs1(rs1),
		.rs2(rs2),
		.rf_rdata1(rf_rdata1),
		.rf_rdata2(rf_rdata2),
		.wb_valid(wb_valid),
		.wb_pc(wb_pc),
		.wb_rd(wb_rd),
		.wb_wen(wb_wen),
		.wb_data(wb_data),
		.wb_illegal(wb_illegal)
	);

endmodule

`default_nettype wire

// File: src/wbu.sv
`default_nettype none

module wbu import core_pkg::*; (
	input  wire                    clock,
	input  wire                    rst_n,
	input  wire                    ex_valid,
	input  wire [xlen-1:0]         ex_pc,
	input  wire [reg_addr_w-1:0]   ex_rd,
	input  wire                    ex_rd_wen,
	input  wire [xlen-1:0]         ex_val,
	input  wire                    ex_illegal,
	input  wire [reg_addr_w-1:0]   rs1,
	input  wire [reg_addr_w-1:0]   rs2,
	output logic [xlen-1:0]        rf_rdata1,
	output logic [xlen-1:0]        rf_rdata2,
	output logic                   wb_valid,
	output logic [xlen-1:0]        wb_pc,
	output logic [reg_addr_w-1:0]  wb_rd,
	output logic                   wb_wen,
	output logic [xlen-1:0]        wb_data,
	output logic                   wb_illegal
);

	logic [xlen-1:0] rf [2**reg_addr_w];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**reg_addr_w; i++) begin
				rf[i] <= '0;
			end
		end else if (ex_valid && ex_rd_wen && (ex_rd != '0)) begin
			rf[ex_rd] <= ex_val;
		end
	end

	// x0 hardwired to zero
	assign rf_rdata1 = (rs1 == '0) ? '0 : rf[rs1];
	assign rf_rdata2 = (rs2 == '0) ? '0 : rf[rs2];

	// Retire record
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wb_valid   <= 1'b0;
			wb_wen     <= 1'b0;
			wb_illegal <= 1'b0;
		end else begin
			wb_valid   <= ex_valid;
			wb_wen     <= ex_valid & ex_rd_wen;
			wb_illegal <= ex_valid & ex_illegal;
		end
	end

	always_ff @(posedge clock) begin
		wb_pc   <= ex_pc;
		wb_rd   <= ex_rd;
		wb_data <= ex_val;
	end

endmodule

`default_nettype wire
